/* src/soc_pkg.sv */
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Data bus types and the fixed memory map
// Regions are naturally aligned powers of two
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`default_nettype none

package soc_pkg;

  typedef logic [31:0] addr_t;
  typedef logic [31:0] data_t;
  typedef logic [3:0]  be_t;

  // One data bus request as the host drives it
  typedef struct packed {
    logic  req;
    logic  we;
    be_t   be;
    addr_t addr;
    data_t wdata;
  } bus_req_t;

  // Response returned one cycle after the grant
  typedef struct packed {
    logic  rvalid;
    logic  err;
    data_t rdata;
  } bus_rsp_t;

  localparam addr_t MEM_START   = 32'h0010_0000;
  localparam addr_t MEM_MASK    = 32'hFFFF_0000;  // 64 KiB

  localparam addr_t GPIO_START  = 32'h8000_0000;
  localparam addr_t GPIO_MASK   = 32'hFFFF_F000;  // 4 KiB

  localparam addr_t TIMER_START = 32'h8000_2000;
  localparam addr_t TIMER_MASK  = 32'hFFFF_F000;  // 4 KiB

  // Register offset inside a peripheral region
  localparam int unsigned REG_OFS_W = 4;
  typedef logic [REG_OFS_W-1:0] reg_ofs_t;

  // Byte-wise merge of a write into an existing register word
  function automatic data_t be_merge(data_t old_word, data_t new_word, be_t be);
    data_t merged;
    merged = old_word;
    for (int b = 0; b < 4; b++) begin
      if (be[b]) begin
        merged[8*b +: 8] = new_word[8*b +: 8];
      end
    end
    return merged;
  endfunction

endpackage

`default_nettype wire

/* src/gpio_regs.sv */
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// GpiWidth and GpoWidth up to 32 bits
// Registers alias across the 4 KiB region
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`default_nettype none
`timescale 1ns/100ps

module gpio_regs #(
  parameter int unsigned GpiWidth = 8,
  parameter int unsigned GpoWidth = 16
) (
  input  wire logic                clk_sys_i,
  input  wire logic                rst_sys_ni,
  input  soc_pkg::bus_req_t        bus_req_i,
  output soc_pkg::bus_rsp_t        bus_rsp_o,
  input  wire logic [GpiWidth-1:0] gp_i,
  output logic [GpoWidth-1:0]      gp_o
);

  import soc_pkg::*;

  localparam reg_ofs_t OfsIn  = 4'h0;
  localparam reg_ofs_t OfsOut = 4'h4;

  logic [GpiWidth-1:0] gpi_meta_q;
  logic [GpiWidth-1:0] gpi_sync_q;
  logic [GpoWidth-1:0] gpo_q;
  reg_ofs_t            ofs;
  data_t               gpo_word;
  data_t               rdata_d;
  data_t               rdata_q;
  logic                rvalid_q;

  assign ofs      = bus_req_i.addr[REG_OFS_W-1:0];
  assign gpo_word = be_merge(data_t'(gpo_q), bus_req_i.wdata, bus_req_i.be);

  always_comb begin
    case (ofs)
      OfsIn:   rdata_d = data_t'(gpi_sync_q);
      OfsOut:  rdata_d = data_t'(gpo_q);
      default: rdata_d = '0;
    endcase
  end

  always_ff @(posedge clk_sys_i or negedge rst_sys_ni) begin
    if (!rst_sys_ni) begin
      gpi_meta_q <= '0;
      gpi_sync_q <= '0;
      gpo_q      <= '0;
      rvalid_q   <= 1'b0;
    end else begin
      gpi_meta_q <= gp_i;        // Two-flop synchronizer
      gpi_sync_q <= gpi_meta_q;
      rvalid_q   <= bus_req_i.req;
      if (bus_req_i.req && bus_req_i.we && (ofs == OfsOut)) begin
        gpo_q <= gpo_word[GpoWidth-1:0];
      end
    end
  end

  always_ff @(posedge clk_sys_i) begin
    if (bus_req_i.req) begin
      rdata_q <= rdata_d;
    end
  end

  assign bus_rsp_o = '{rvalid: rvalid_q, err: 1'b0, rdata: rdata_q};
  assign gp_o      = gpo_q;

endmodule

`default_nettype wire

/* src/timer_regs.sv */
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// mtime counts system clock cycles
// Interrupt lags the comparison by one cycle
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`default_nettype none
`timescale 1ns/100ps

module timer_regs (
  input  wire logic         clk_sys_i,
  input  wire logic         rst_sys_ni,
  input  soc_pkg::bus_req_t bus_req_i,
  output soc_pkg::bus_rsp_t bus_rsp_o,
  output logic              timer_irq_o
);

  import soc_pkg::*;

  localparam reg_ofs_t OfsTimeLo = 4'h0;
  localparam reg_ofs_t OfsTimeHi = 4'h4;
  localparam reg_ofs_t OfsCmpLo  = 4'h8;
  localparam reg_ofs_t OfsCmpHi  = 4'hC;

  logic [63:0] mtime_q;
  logic [63:0] mtime_d;
  logic [63:0] mtimecmp_q;
  logic [63:0] mtimecmp_d;
  reg_ofs_t    ofs;
  logic        wr_en;
  data_t       rdata_d;
  data_t       rdata_q;
  logic        rvalid_q;
  logic        irq_q;

  assign ofs   = bus_req_i.addr[REG_OFS_W-1:0];
  assign wr_en = bus_req_i.req & bus_req_i.we;

  // A bus write takes priority over the increment of that half
  always_comb begin
    mtime_d    = mtime_q + 64'd1;
    mtimecmp_d = mtimecmp_q;
    if (wr_en) begin
      case (ofs)
        OfsTimeLo: mtime_d[31:0]     = be_merge(mtime_q[31:0], bus_req_i.wdata, bus_req_i.be);
        OfsTimeHi: mtime_d[63:32]    = be_merge(mtime_q[63:32], bus_req_i.wdata, bus_req_i.be);
        OfsCmpLo:  mtimecmp_d[31:0]  = be_merge(mtimecmp_q[31:0], bus_req_i.wdata,
                                                bus_req_i.be);
        OfsCmpHi:  mtimecmp_d[63:32] = be_merge(mtimecmp_q[63:32], bus_req_i.wdata,
                                                bus_req_i.be);
        default: ;
      endcase
    end
  end

  always_comb begin
    case (ofs)
      OfsTimeLo: rdata_d = mtime_q[31:0];
      OfsTimeHi: rdata_d = mtime_q[63:32];
      OfsCmpLo:  rdata_d = mtimecmp_q[31:0];
      OfsCmpHi:  rdata_d = mtimecmp_q[63:32];
      default:   rdata_d = '0;
    endcase
  end

  always_ff @(posedge clk_sys_i or negedge rst_sys_ni) begin
    if (!rst_sys_ni) begin
      mtime_q    <= '0;
      mtimecmp_q <= '1;  // No interrupt until software sets a compare value
      rvalid_q   <= 1'b0;
      irq_q      <= 1'b0;
    end else begin
      mtime_q    <= mtime_d;
      mtimecmp_q <= mtimecmp_d;
      rvalid_q   <= bus_req_i.req;
      irq_q      <= mtime_q >= mtimecmp_q;  // Level, held while the condition lasts
    end
  end

  always_ff @(posedge clk_sys_i) begin
    if (bus_req_i.req) begin
      rdata_q <= rdata_d;
    end
  end

  assign bus_rsp_o   = '{rvalid: rvalid_q, err: 1'b0, rdata: rdata_q};
  assign timer_irq_o = irq_q;

endmodule

`default_nettype wire

/* src/instr_fetch_path.sv */
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Grants only fetches inside RAM
// Core must hold request and address until grant
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`default_nettype none
`timescale 1ns/100ps

module instr_fetch_path #(
  parameter int unsigned FetchDelay = 3
) (
  input  wire logic      clk_sys_i,
  input  wire logic      rst_sys_ni,

  input  wire logic      fetch_req_i,
  input  soc_pkg::addr_t fetch_addr_i,
  output logic           fetch_gnt_o,
  output logic           fetch_rvalid_o,
  output soc_pkg::data_t fetch_rdata_o,

  output logic           mem1_req_o,
  output soc_pkg::addr_t mem1_addr_o,
  input  soc_pkg::data_t mem1_rdata_i
);

  import soc_pkg::*;

  localparam int unsigned CntW = (FetchDelay > 0) ? $clog2(FetchDelay + 1) : 1;
  localparam logic [CntW-1:0] CntMax = CntW'(FetchDelay);

  logic [CntW-1:0] wait_cnt_q;
  logic            delay_done;
  logic            in_ram;
  logic            gnt;
  logic            rvalid_q;

  // Counts earlier cycles of a held request, saturating
  assign delay_done = wait_cnt_q == CntMax;
  assign in_ram     = (fetch_addr_i & MEM_MASK) == MEM_START;
  assign gnt        = fetch_req_i & delay_done & in_ram;

  always_ff @(posedge clk_sys_i or negedge rst_sys_ni) begin
    if (!rst_sys_ni) begin
      wait_cnt_q <= '0;
      rvalid_q   <= 1'b0;
    end else begin
      rvalid_q <= gnt;
      if (!fetch_req_i || gnt) begin
        wait_cnt_q <= '0;  // Restart for the next fetch
      end else if (!delay_done) begin
        wait_cnt_q <= wait_cnt_q + 1'b1;
      end
    end
  end

  assign fetch_gnt_o    = gnt;
  assign mem1_req_o     = gnt;           // Memory request issued with the grant
  assign mem1_addr_o    = fetch_addr_i;
  assign fetch_rvalid_o = rvalid_q;
  assign fetch_rdata_o  = mem1_rdata_i;  // Valid together with fetch_rvalid_o

endmodule

`default_nettype wire

/* src/data_bus_decode.sv */
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Grants every request at once, no back-pressure
// All devices must answer in the cycle after the grant
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`default_nettype none
`timescale 1ns/100ps

module data_bus_decode (
  input  wire logic         clk_sys_i,
  input  wire logic         rst_sys_ni,

  input  soc_pkg::bus_req_t host_req_i,
  output logic              host_gnt_o,
  output soc_pkg::bus_rsp_t host_rsp_o,

  output soc_pkg::bus_req_t gpio_req_o,
  input  soc_pkg::bus_rsp_t gpio_rsp_i,
  output soc_pkg::bus_req_t timer_req_o,
  input  soc_pkg::bus_rsp_t timer_rsp_i,

  output soc_pkg::bus_req_t mem0_req_o,
  input  wire logic         mem0_rvalid_i,
  input  soc_pkg::data_t    mem0_rdata_i
);

  import soc_pkg::*;

  localparam int unsigned DevRam   = 0;
  localparam int unsigned DevGpio  = 1;
  localparam int unsigned DevTimer = 2;
  localparam int unsigned NumDev   = 3;

  logic [NumDev-1:0] dev_hit;
  logic [NumDev-1:0] dev_sel_q;  // One-hot, valid in the response cycle
  logic              unmapped;
  logic              unmapped_q;

  assign dev_hit[DevRam]   = (host_req_i.addr & MEM_MASK) == MEM_START;
  assign dev_hit[DevGpio]  = (host_req_i.addr & GPIO_MASK) == GPIO_START;
  assign dev_hit[DevTimer] = (host_req_i.addr & TIMER_MASK) == TIMER_START;
  assign unmapped          = host_req_i.req & ~|dev_hit;

  assign host_gnt_o = host_req_i.req;

  // Fields are copied, only req is qualified by the decode
  always_comb begin
    mem0_req_o      = host_req_i;
    gpio_req_o      = host_req_i;
    timer_req_o     = host_req_i;
    mem0_req_o.req  = host_req_i.req & dev_hit[DevRam];
    gpio_req_o.req  = host_req_i.req & dev_hit[DevGpio];
    timer_req_o.req = host_req_i.req & dev_hit[DevTimer];
  end

  always_ff @(posedge clk_sys_i or negedge rst_sys_ni) begin
    if (!rst_sys_ni) begin
      dev_sel_q  <= '0;
      unmapped_q <= 1'b0;
    end else begin
      dev_sel_q  <= host_req_i.req ? dev_hit : '0;
      unmapped_q <= unmapped;
    end
  end

  always_comb begin
    host_rsp_o.rvalid = unmapped_q
                      | (dev_sel_q[DevRam] & mem0_rvalid_i)
                      | (dev_sel_q[DevGpio] & gpio_rsp_i.rvalid)
                      | (dev_sel_q[DevTimer] & timer_rsp_i.rvalid);
    host_rsp_o.err    = unmapped_q
                      | (dev_sel_q[DevGpio] & gpio_rsp_i.err)
                      | (dev_sel_q[DevTimer] & timer_rsp_i.err);
    if (dev_sel_q[DevRam]) begin
      host_rsp_o.rdata = mem0_rdata_i;
    end else if (dev_sel_q[DevGpio]) begin
      host_rsp_o.rdata = gpio_rsp_i.rdata;
    end else if (dev_sel_q[DevTimer]) begin
      host_rsp_o.rdata = timer_rsp_i.rdata;
    end else begin
      host_rsp_o.rdata = '0;  // Error response and idle
    end
  end

endmodule

`default_nettype wire

/* src/memless_soc_top.sv */
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// External RAM must answer both ports in the next cycle
// Fetches outside RAM are never granted
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`default_nettype none
`timescale 1ns/100ps

module memless_soc_top #(
  parameter int unsigned GpiWidth   = 8,
  parameter int unsigned GpoWidth   = 16,
  parameter int unsigned FetchDelay = 3
) (
  input  wire logic              clk_sys_i,
  input  wire logic              rst_sys_ni,

  // Data host port
  input  soc_pkg::bus_req_t      data_req_i,
  output logic                   data_gnt_o,
  output soc_pkg::bus_rsp_t      data_rsp_o,

  // Instruction fetch port
  input  wire logic              fetch_req_i,
  input  soc_pkg::addr_t         fetch_addr_i,
  output logic                   fetch_gnt_o,
  output logic                   fetch_rvalid_o,
  output soc_pkg::data_t         fetch_rdata_o,

  // External memory, port 0 for data and port 1 for fetches
  output soc_pkg::bus_req_t      mem0_req_o,
  input  wire logic              mem0_rvalid_i,
  input  soc_pkg::data_t         mem0_rdata_i,
  output logic                   mem1_req_o,
  output soc_pkg::addr_t         mem1_addr_o,
  input  soc_pkg::data_t         mem1_rdata_i,

  input  wire logic [GpiWidth-1:0] gp_i,
  output logic [GpoWidth-1:0]    gp_o,
  output logic                   timer_irq_o
);

  import soc_pkg::*;

  bus_req_t gpio_req;
  bus_req_t timer_req;
  bus_rsp_t gpio_rsp;
  bus_rsp_t timer_rsp;

  data_bus_decode u_data_bus_decode (
    .clk_sys_i     (clk_sys_i),
    .rst_sys_ni    (rst_sys_ni),
    .host_req_i    (data_req_i),
    .host_gnt_o    (data_gnt_o),
    .host_rsp_o    (data_rsp_o),
    .gpio_req_o    (gpio_req),
    .gpio_rsp_i    (gpio_rsp),
    .timer_req_o   (timer_req),
    .timer_rsp_i   (timer_rsp),
    .mem0_req_o    (mem0_req_o),
    .mem0_rvalid_i (mem0_rvalid_i),
    .mem0_rdata_i  (mem0_rdata_i)
  );

  gpio_regs #(
    .GpiWidth (GpiWidth),
    .GpoWidth (GpoWidth)
  ) u_gpio_regs (
    .clk_sys_i  (clk_sys_i),
    .rst_sys_ni (rst_sys_ni),
    .bus_req_i  (gpio_req),
    .bus_rsp_o  (gpio_rsp),
    .gp_i       (gp_i),
    .gp_o       (gp_o)
  );

  timer_regs u_timer_regs (
    .clk_sys_i   (clk_sys_i),
    .rst_sys_ni  (rst_sys_ni),
    .bus_req_i   (timer_req),
    .bus_rsp_o   (timer_rsp),
    .timer_irq_o (timer_irq_o)
  );

  instr_fetch_path #(
    .FetchDelay (FetchDelay)
  ) u_instr_fetch_path (
    .clk_sys_i      (clk_sys_i),
    .rst_sys_ni     (rst_sys_ni),
    .fetch_req_i    (fetch_req_i),
    .fetch_addr_i   (fetch_addr_i),
    .fetch_gnt_o    (fetch_gnt_o),
    .fetch_rvalid_o (fetch_rvalid_o),
    .fetch_rdata_o  (fetch_rdata_o),
    .mem1_req_o     (mem1_req_o),
    .mem1_addr_o    (mem1_addr_o),
    .mem1_rdata_i   (mem1_rdata_i)
  );

endmodule

`default_nettype wire

/* testbench/memless_soc_properties.sv */
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Bus timing rules, bound into the decoder and the fetch path
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`default_nettype none
`timescale 1ns/100ps

module memless_soc_properties #(
  parameter bit CheckRange = 1'b0  // Set where mem_req_i must stay inside RAM
) (
  input  wire logic      clk_sys_i,
  input  wire logic      rst_sys_ni,
  input  wire logic      gnt_i,
  input  wire logic      rvalid_i,
  input  wire logic      mem_req_i,
  input  soc_pkg::addr_t mem_addr_i
);

  import soc_pkg::*;

  rvalid_after_gnt: assert property (@(posedge clk_sys_i) disable iff (!rst_sys_ni)
    gnt_i |=> rvalid_i) else $error("rvalid missing one cycle after a grant");

  rvalid_needs_gnt: assert property (@(posedge clk_sys_i) disable iff (!rst_sys_ni)
    rvalid_i |-> $past(gnt_i)) else $error("rvalid without a grant in the cycle before");

  if (CheckRange) begin : g_range
    mem_req_in_ram: assert property (@(posedge clk_sys_i) disable iff (!rst_sys_ni)
      mem_req_i |-> ((mem_addr_i & MEM_MASK) == MEM_START))
      else $error("memory request outside the RAM range");
  end

endmodule

bind data_bus_decode memless_soc_properties #(.CheckRange(1'b0)) u_bus_props (
  .clk_sys_i  (clk_sys_i),
  .rst_sys_ni (rst_sys_ni),
  .gnt_i      (host_gnt_o),
  .rvalid_i   (host_rsp_o.rvalid),
  .mem_req_i  (1'b0),
  .mem_addr_i (32'h0)
);

bind instr_fetch_path memless_soc_properties #(.CheckRange(1'b1)) u_fetch_props (
  .clk_sys_i  (clk_sys_i),
  .rst_sys_ni (rst_sys_ni),
  .gnt_i      (fetch_gnt_o),
  .rvalid_i   (fetch_rvalid_o),
  .mem_req_i  (mem1_req_o),
  .mem_addr_i (mem1_addr_o)
);

`default_nettype wire

/* testbench/tb_memless_soc.sv */
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// RAM model of 256 words aliased over the 64 KiB region
// Inputs change 1 ns after the rising edge and outputs are sampled at 2 ns
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`default_nettype none
`timescale 1ns/100ps

module tb_memless_soc;

  import soc_pkg::*;

  localparam int unsigned GpiWidth   = 8;
  localparam int unsigned GpoWidth   = 16;
  localparam int unsigned FetchDelay = 3;
  localparam int unsigned Timeout    = 50;
  localparam data_t       GpoMask    = data_t'((64'd1 << GpoWidth) - 64'd1);

  typedef struct {
    string name;
    addr_t addr;
    logic  we;
    be_t   be;
    data_t wdata;
    logic  chk_rdata;  // Writes leave rdata unchecked
    data_t exp_rdata;
    logic  exp_err;
  } row_t;

  logic                clk_sys = 1'b0;
  logic                rst_sys_n;
  bus_req_t            data_req;
  logic                data_gnt;
  bus_rsp_t            data_rsp;
  logic                fetch_req;
  addr_t               fetch_addr;
  logic                fetch_gnt;
  logic                fetch_rvalid;
  data_t               fetch_rdata;
  bus_req_t            mem0_req;
  logic                mem0_rvalid = 1'b0;
  data_t               mem0_rdata = '0;
  logic                mem1_req;
  addr_t               mem1_addr;
  data_t               mem1_rdata = '0;
  logic [GpiWidth-1:0] gp_in;
  logic [GpoWidth-1:0] gp_out;
  logic                timer_irq;

  data_t ram [256];
  data_t lfsr_state = 32'h6ea001d0;
  int    errors = 0;
  int    tests_run = 0;
  int    tests_failed = 0;

  always #2 clk_sys = ~clk_sys;

  memless_soc_top #(
    .GpiWidth   (GpiWidth),
    .GpoWidth   (GpoWidth),
    .FetchDelay (FetchDelay)
  ) dut_i (
    .clk_sys_i (clk_sys), .rst_sys_ni (rst_sys_n),
    .data_req_i (data_req), .data_gnt_o (data_gnt), .data_rsp_o (data_rsp),
    .fetch_req_i (fetch_req), .fetch_addr_i (fetch_addr), .fetch_gnt_o (fetch_gnt),
    .fetch_rvalid_o (fetch_rvalid), .fetch_rdata_o (fetch_rdata),
    .mem0_req_o (mem0_req), .mem0_rvalid_i (mem0_rvalid), .mem0_rdata_i (mem0_rdata),
    .mem1_req_o (mem1_req), .mem1_addr_o (mem1_addr), .mem1_rdata_i (mem1_rdata),
    .gp_i (gp_in), .gp_o (gp_out), .timer_irq_o (timer_irq)
  );

  // Galois LFSR stepped once per bit taken
  function automatic data_t take_bits(input int unsigned nbits);
    data_t val;
    val = '0;
    for (int i = 0; i < nbits; i++) begin
      val        = {val[30:0], lfsr_state[0]};
      lfsr_state = lfsr_state[0] ? ((lfsr_state >> 1) ^ 32'h80200003) : (lfsr_state >> 1);
    end
    return val;
  endfunction

  function automatic data_t merge_bytes(input data_t old_w, input data_t new_w, input be_t be);
    data_t mask;
    mask = {{8{be[3]}}, {8{be[2]}}, {8{be[1]}}, {8{be[0]}}};
    return (old_w & ~mask) | (new_w & mask);
  endfunction

  // Both ports answer in the cycle after the request
  always @(posedge clk_sys) begin
    mem0_rvalid <= mem0_req.req;
    if (mem0_req.req) begin
      mem0_rdata <= ram[mem0_req.addr[9:2]];
      if (mem0_req.we) begin
        ram[mem0_req.addr[9:2]] <= merge_bytes(ram[mem0_req.addr[9:2]], mem0_req.wdata,
                                               mem0_req.be);
      end
    end
    if (mem1_req) begin
      mem1_rdata <= ram[mem1_addr[9:2]];
    end
  end

  task automatic check_value(input string name, input data_t exp, input data_t act);
    assert (exp === act) else begin
      $display("ERR %s expected %h actual %h", name, exp, act);
      errors++;
    end
  endtask

  task automatic check_true(input logic cond, input string what);
    assert (cond === 1'b1) else begin
      $display("Error: %s", what);
      errors++;
    end
  endtask

  task automatic finish_test(input string name, input int errs_before);
    tests_run++;
    if (errors == errs_before) begin
      $display("test %-12s ok", name);
    end else begin
      tests_failed++;
      $display("test %-12s failed", name);
    end
  endtask

  // One data bus transfer granted in the request cycle
  task automatic bus_access(input row_t row, output data_t rdata, output logic err);
    int n;
    @(posedge clk_sys);
    #1 data_req = '{req: 1'b1, we: row.we, be: row.be, addr: row.addr, wdata: row.wdata};
    #1;
    check_true(data_gnt, {row.name, ": no data grant in the request cycle"});
    if ((row.addr & MEM_MASK) == MEM_START) begin
      check_true(mem0_req === data_req, {row.name, ": mem0 request differs from host request"});
    end else begin
      check_true(!mem0_req.req, {row.name, ": mem0 request outside RAM"});
    end
    @(posedge clk_sys);
    #1 data_req = '0;
    #1;
    n = 0;
    while (!data_rsp.rvalid && n < Timeout) begin
      @(posedge clk_sys);
      #2 n++;
    end
    check_true(data_rsp.rvalid, {row.name, ": no data rvalid before the timeout"});
    check_true(n == 0, {row.name, ": data rvalid not one cycle after the grant"});
    rdata = data_rsp.rdata;
    err   = data_rsp.err;
  endtask

  task automatic fetch_check(input string name, input addr_t addr, input logic in_ram);
    int n;
    int errs_before;
    errs_before = errors;
    @(posedge clk_sys);
    #1 fetch_req = 1'b1;
    fetch_addr = addr;
    #1;
    n = 0;
    while (!fetch_gnt && n < Timeout) begin
      @(posedge clk_sys);
      #2 n++;
    end
    if (in_ram) begin
      check_true(fetch_gnt, {name, ": fetch not granted before the timeout"});
      check_value({name, " delay"}, FetchDelay, n);
      check_true(mem1_req && (mem1_addr === addr), {name, ": port 1 request missing"});
      @(posedge clk_sys);
      #1 fetch_req = 1'b0;
      #1;
      n = 0;
      while (!fetch_rvalid && n < Timeout) begin
        @(posedge clk_sys);
        #2 n++;
      end
      check_true(n == 0, {name, ": fetch rvalid not one cycle after the grant"});
      check_value({name, " data"}, ram[addr[9:2]], fetch_rdata);
    end else begin
      check_true(!fetch_gnt, {name, ": fetch outside RAM was granted"});
      @(posedge clk_sys);
      #1 fetch_req = 1'b0;
    end
    finish_test(name, errs_before);
  endtask

  initial begin
    row_t                rows[$];
    row_t                row;
    data_t               rdata;
    data_t               t0;
    data_t               w;
    data_t               gpo_exp;
    logic                err;
    logic [GpiWidth-1:0] gpi_val;
    int                  n;
    int                  errs_before;
    rst_sys_n   = 1'b0;
    data_req    = '0;
    fetch_req   = 1'b0;
    fetch_addr  = '0;
    for (int i = 0; i < 256; i++) begin
      ram[i] <= take_bits(32);
    end
    gpi_val = GpiWidth'(take_bits(GpiWidth));
    gp_in   = gpi_val;  // Held for the whole run
    repeat (3) @(posedge clk_sys);
    #1 rst_sys_n = 1'b1;
    #1;
    errs_before = errors;
    check_true(!timer_irq, "timer interrupt high after reset");
    finish_test("timer_reset", errs_before);

    w       = take_bits(32);
    gpo_exp = merge_bytes(32'h0, w, 4'hF) & GpoMask;
    rows.push_back('{"gpo_full", GPIO_START + 32'h4, 1'b1, 4'hF, w, 1'b0, 32'h0, 1'b0});
    w       = take_bits(32);
    gpo_exp = merge_bytes(gpo_exp, w, 4'b0010) & GpoMask;
    rows.push_back('{"gpo_byte1", GPIO_START + 32'h4, 1'b1, 4'b0010, w, 1'b0, 32'h0, 1'b0});
    rows.push_back('{"gpo_read", GPIO_START + 32'h4, 1'b0, 4'hF, 32'h0, 1'b1, gpo_exp, 1'b0});
    rows.push_back('{"gpi_read", GPIO_START, 1'b0, 4'hF, 32'h0, 1'b1, 32'(gpi_val), 1'b0});
    w = take_bits(32);
    rows.push_back('{"ram_write", MEM_START + 32'h40, 1'b1, 4'b0101, w, 1'b0, 32'h0, 1'b0});
    rows.push_back('{"ram_read", MEM_START + 32'h40, 1'b0, 4'hF, 32'h0, 1'b1,
                     merge_bytes(ram[16], w, 4'b0101), 1'b0});
    rows.push_back('{"ram_read_top", MEM_START + 32'h3FC, 1'b0, 4'hF, 32'h0, 1'b1, ram[255],
                     1'b0});
    rows.push_back('{"unmapped_rd", 32'h4000_0000, 1'b0, 4'hF, 32'h0, 1'b1, 32'h0, 1'b1});
    rows.push_back('{"unmapped_wr", 32'h0020_0000, 1'b1, 4'hF, 32'hDEAD_BEEF, 1'b1, 32'h0,
                     1'b1});

    foreach (rows[i]) begin
      errs_before = errors;
      bus_access(rows[i], rdata, err);
      check_value({rows[i].name, " err"}, 32'(rows[i].exp_err), 32'(err));
      if (rows[i].chk_rdata) begin
        check_value(rows[i].name, rows[i].exp_rdata, rdata);
      end
      if (rows[i].name == "gpo_byte1") begin
        check_value({rows[i].name, " gp_o"}, gpo_exp, 32'(gp_out));
      end
      finish_test(rows[i].name, errs_before);
    end

    fetch_check("fetch_ram", MEM_START + 32'h80, 1'b1);
    fetch_check("fetch_written", MEM_START + 32'h40, 1'b1);
    fetch_check("fetch_outside", 32'h8000_0000, 1'b0);

    errs_before = errors;
    row = '{"mtime_lo", TIMER_START, 1'b0, 4'hF, 32'h0, 1'b0, 32'h0, 1'b0};
    bus_access(row, t0, err);
    bus_access(row, rdata, err);
    check_true(rdata > t0, "mtime low did not increase between two reads");
    bus_access('{"cmp_hi", TIMER_START + 32'hC, 1'b1, 4'hF, 32'h0, 1'b0, 32'h0, 1'b0}, rdata, err);
    bus_access('{"cmp_lo", TIMER_START + 32'h8, 1'b1, 4'hF, 32'h0, 1'b0, 32'h0, 1'b0}, rdata, err);
    n = 0;
    while (!timer_irq && n < Timeout) begin
      @(posedge clk_sys);
      #2 n++;
    end
    check_true(timer_irq, "timer interrupt did not rise after mtimecmp was cleared");
    bus_access('{"cmp_lo", TIMER_START + 32'h8, 1'b1, 4'hF, '1, 1'b0, 32'h0, 1'b0}, rdata, err);
    bus_access('{"cmp_hi", TIMER_START + 32'hC, 1'b1, 4'hF, '1, 1'b0, 32'h0, 1'b0}, rdata, err);
    n = 0;
    while (timer_irq && n < Timeout) begin
      @(posedge clk_sys);
      #2 n++;
    end
    check_true(!timer_irq, "timer interrupt did not fall after mtimecmp was set to all ones");
    finish_test("timer", errs_before);

    $display("tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, errors);
    if (errors == 0 && tests_failed == 0) begin
      $display("=== PASS ===");
    end else begin
      $display("=== FAIL ===");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* verilog.f */
src/soc_pkg.sv
src/gpio_regs.sv
src/timer_regs.sv
src/instr_fetch_path.sv
src/data_bus_decode.sv
src/memless_soc_top.sv
testbench/memless_soc_properties.sv
testbench/tb_memless_soc.sv

/* Bender.yml */
package:
  name: memless_soc

sources:
  - src/soc_pkg.sv
  - src/gpio_regs.sv
  - src/timer_regs.sv
  - src/instr_fetch_path.sv
  - src/data_bus_decode.sv
  - src/memless_soc_top.sv
  - target: test
    files:
      - testbench/memless_soc_properties.sv
      - testbench/tb_memless_soc.sv
